//--- src.f
hw/router_pkg.sv
hw/queue_pkg.sv
hw/pkt_classifier.sv
hw/queue_store.sv
hw/egress_scheduler.sv
hw/p4_queue_system.sv
bench/tb_p4_queue_system.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the queue system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_p4_queue_system \
    -f src.f -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

//--- bench/tb_p4_queue_system.sv
/* Queue system testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_p4_queue_system;

    localparam int queue_depth = 16;
    localparam int in_limit    = 2000;
    localparam int drain_limit = 4000;

    logic                                 core_clk_ifc;
    logic                                 rst_n;
    router_pkg::stream_word_t             in_word;
    logic                                 in_valid;
    logic                                 in_ready;
    logic [router_pkg::num_egr_ports-1:0] egr_ready;
    router_pkg::stream_word_t             out_word;
    logic                                 out_valid;

    // Expected words per queue, in send order
    router_pkg::stream_word_t exp_q [queue_pkg::num_queues][$];
    // Queue of every packet as its last word leaves
    queue_pkg::queue_idx_t    done_log [$];

    int                                   sent_pkts [router_pkg::num_egr_ports];
    int                                   recv_pkts [router_pkg::num_egr_ports];
    int                                   errors;
    int                                   timeouts;
    int                                   words_checked;
    logic [31:0]                          rng_state;
    logic [router_pkg::num_egr_ports-1:0] rdy_d1 = '1;
    logic [router_pkg::num_egr_ports-1:0] rdy_d2 = '1;

    p4_queue_system #(
        .queue_depth ( queue_depth )
    ) i_p4_queue_system (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .in_word      ( in_word      ),
        .in_valid     ( in_valid     ),
        .in_ready     ( in_ready     ),
        .egr_ready    ( egr_ready    ),
        .out_word     ( out_word     ),
        .out_valid    ( out_valid    )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever begin
            #50 core_clk_ifc = ~core_clk_ifc;
        end
    end

    //////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int q = 0; q < queue_pkg::num_queues; q++) begin
            n += exp_q[q].size();
        end
        return n;
    endfunction

    // Drives one packet; a first word held off for block_limit cycles opens all ports
    task automatic send_pkt(
        input  router_pkg::egr_port_t port,
        input  router_pkg::prio_t     prio,
        input  router_pkg::byte_len_t len,
        input  int                    block_limit,
        output bit                    blocked
    );
        router_pkg::stream_word_t w;
        queue_pkg::queue_idx_t    q;
        int                       nw;
        int                       waited;
        bit                       taken;
        blocked = 1'b0;
        q       = {port, prio};
        nw      = (int'(len) + 7) / 8;
        for (int i = 0; i < nw; i++) begin
            w.data          = {next_rand(), next_rand()};
            w.last          = (i == nw - 1);
            w.meta.egr_port = port;
            w.meta.prio     = prio;
            w.meta.byte_len = len;
            @(negedge core_clk_ifc);
            in_word  = w;
            in_valid = 1'b1;
            waited   = 0;
            taken    = 1'b0;
            while (!taken && waited < in_limit) begin
                @(posedge core_clk_ifc);
                if (in_ready) begin
                    taken = 1'b1;
                end else begin
                    waited++;
                    if (i == 0 && block_limit > 0 && waited == block_limit) begin
                        blocked = 1'b1;
                        @(negedge core_clk_ifc);
                        egr_ready = '1;
                    end
                end
            end
            if (!taken) begin
                $display("Timeout: in_ready stayed low for %0d cycles, queue %0d", in_limit, q);
                timeouts++;
                @(negedge core_clk_ifc);
                in_valid = 1'b0;
                return;
            end
            exp_q[q].push_back(w);
        end
        sent_pkts[port]++;
        @(negedge core_clk_ifc);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending_words() != 0 && n < drain_limit) begin
            @(posedge core_clk_ifc);
            n++;
        end
        if (pending_words() != 0) begin
            $display("Timeout: %0d words never left the DUT", pending_words());
            timeouts++;
        end
        // Room for a stray word to show up
        repeat (4) @(posedge core_clk_ifc);
    endtask

    task automatic compare_port_counts();
        for (int p = 0; p < router_pkg::num_egr_ports; p++) begin
            if (recv_pkts[p] != sent_pkts[p]) begin
                $display("Fail %0t out_word packets on port %0d expected %0d got %0d",
                         $time, p, sent_pkts[p], recv_pkts[p]);
                errors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Output monitor

    always @(posedge core_clk_ifc) begin : out_monitor
        router_pkg::egr_port_t    p;
        queue_pkg::queue_idx_t    q;
        router_pkg::stream_word_t exp;
        if (rst_n && out_valid) begin
            p = out_word.meta.egr_port;
            q = {p, out_word.meta.prio};
            words_checked++;
            if (!rdy_d1[p] && !rdy_d2[p]) begin
                $display("Fail %0t out_valid expected 0 got 1, port %0d ready low two cycles",
                         $time, p);
                errors++;
            end
            if (exp_q[q].size() == 0) begin
                $display("Unexpected word on out_word for queue %0d at %0t", q, $time);
                errors++;
            end else begin
                exp = exp_q[q].pop_front();
                if (out_word !== exp) begin
                    $display("Fail %0t out_word expected %h got %h", $time, exp, out_word);
                    errors++;
                end
            end
            if (out_word.last) begin
                done_log.push_back(q);
                recv_pkts[p]++;
            end
        end
        rdy_d2 = rdy_d1;
        rdy_d1 = egr_ready;
    end

    //////////////////////////////////////////////////
    // Directed tests

    task automatic check_after_reset();
        router_pkg::stream_word_t w;
        repeat (3) begin
            @(posedge core_clk_ifc);
            if (out_valid !== 1'b0) begin
                $display("Fail %0t out_valid expected 0 got %b", $time, out_valid);
                errors++;
            end
        end
        // Empty queues take a valid first word at once
        w.data          = {next_rand(), next_rand()};
        w.last          = 1'b1;
        w.meta.egr_port = 2'd3;
        w.meta.prio     = 1'b1;
        w.meta.byte_len = 7'd8;
        @(negedge core_clk_ifc);
        in_word  = w;
        in_valid = 1'b1;
        @(posedge core_clk_ifc);
        if (in_ready !== 1'b1) begin
            $display("Fail %0t in_ready expected 1 got %b", $time, in_ready);
            errors++;
        end else begin
            exp_q[3'b111].push_back(w);
            sent_pkts[3]++;
        end
        @(negedge core_clk_ifc);
        in_valid = 1'b0;
        wait_drain();
    endtask

    task automatic send_one_packet();
        bit blocked;
        send_pkt(router_pkg::egr_port_t'(next_rand() % 4), router_pkg::prio_t'(next_rand() % 2),
                 router_pkg::byte_len_t'(next_rand() % 64 + 1), 0, blocked);
        wait_drain();
        compare_port_counts();
    endtask

    task automatic send_packet_train();
        bit blocked;
        repeat (20) begin
            send_pkt(2'd1, 1'b0, router_pkg::byte_len_t'(next_rand() % 64 + 1), 0, blocked);
        end
        wait_drain();
        compare_port_counts();
    endtask

    task automatic check_priority_order();
        bit blocked;
        @(negedge core_clk_ifc);
        egr_ready = 4'b1011;
        send_pkt(2'd2, 1'b0, router_pkg::byte_len_t'(next_rand() % 64 + 1), 0, blocked);
        send_pkt(2'd2, 1'b1, router_pkg::byte_len_t'(next_rand() % 64 + 1), 0, blocked);
        // Enqueue plus store update
        repeat (3) @(posedge core_clk_ifc);
        done_log.delete();
        @(negedge core_clk_ifc);
        egr_ready = '1;
        wait_drain();
        if (done_log.size() != 2) begin
            $display("Expected 2 packets on port 2 but saw %0d", done_log.size());
            errors++;
        end else if (done_log[0] != 3'b101) begin
            $display("Fail %0t out_word.meta queue expected 5 got %0d", $time, done_log[0]);
            errors++;
        end
        compare_port_counts();
    endtask

    task automatic run_egress_backpressure();
        bit          blocked;
        bit          sending_done;
        logic [31:0] ready_state;
        sending_done = 1'b0;
        ready_state  = next_rand();
        fork
            begin
                repeat (200) begin
                    send_pkt(router_pkg::egr_port_t'(next_rand() % 4),
                             router_pkg::prio_t'(next_rand() % 2),
                             router_pkg::byte_len_t'(next_rand() % 64 + 1), 0, blocked);
                end
                sending_done = 1'b1;
            end
            begin
                while (!sending_done) begin
                    @(negedge core_clk_ifc);
                    ready_state = xorshift(ready_state);
                    egr_ready   = ready_state[3:0];
                end
                @(negedge core_clk_ifc);
                egr_ready = '1;
            end
        join
        wait_drain();
        compare_port_counts();
    endtask

    task automatic run_ingress_backpressure();
        bit blocked;
        int clean;
        int tries;
        clean   = 0;
        tries   = 0;
        blocked = 1'b0;
        @(negedge core_clk_ifc);
        egr_ready = 4'b1110;
        done_log.delete();
        // 64-byte packets fill queue 0 in two
        while (!blocked && tries < 4) begin
            send_pkt(2'd0, 1'b0, 7'd64, 20, blocked);
            if (!blocked) begin
                clean++;
            end
            tries++;
        end
        if (!blocked) begin
            $display("in_ready never stayed low for 20 cycles on a full queue");
            errors++;
        end
        if (clean != 2) begin
            $display("Fail %0t in_ready packets accepted expected 2 got %0d", $time, clean);
            errors++;
        end
        wait_drain();
        if (done_log.size() != tries) begin
            $display("Expected %0d packets from queue 0 but saw %0d", tries, done_log.size());
            errors++;
        end
        compare_port_counts();
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        rng_state     = 32'h20ff3e40;
        errors        = 0;
        timeouts      = 0;
        words_checked = 0;
        for (int p = 0; p < router_pkg::num_egr_ports; p++) begin
            sent_pkts[p] = 0;
            recv_pkts[p] = 0;
        end
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_word   = '0;
        egr_ready = '1;
        repeat (10) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        rst_n = 1'b1;

        check_after_reset();
        send_one_packet();
        send_packet_train();
        check_priority_order();
        run_egress_backpressure();
        run_ingress_backpressure();

        $display("Summary: %0d mismatches, %0d timeouts, %0d words checked",
                 errors, timeouts, words_checked);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/p4_queue_system.sv
/* Egress packet queue system */

`timescale 1ns/1ps
`default_nettype none

module p4_queue_system #(
    parameter int queue_depth = 16
) (
    input  logic                                  core_clk_ifc,
    input  logic                                  rst_n,
    input  router_pkg::stream_word_t              in_word,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [router_pkg::num_egr_ports-1:0]  egr_ready,
    output router_pkg::stream_word_t              out_word,
    output logic                                  out_valid
);

    queue_pkg::enq_word_t                  enq_word;
    logic                                  enq_valid;
    logic [$clog2(queue_depth+1)-1:0]      free_words [queue_pkg::num_queues];
    logic [queue_pkg::num_queues-1:0]      pkt_avail;
    queue_pkg::deq_req_t                   deq_req;
    logic                                  deq_valid;
    router_pkg::stream_word_t              deq_word;

    // Producer
    pkt_classifier #(
        .queue_depth ( queue_depth )
    ) i_pkt_classifier (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .in_word      ( in_word      ),
        .in_valid     ( in_valid     ),
        .in_ready     ( in_ready     ),
        .free_words   ( free_words   ),
        .enq_word     ( enq_word     ),
        .enq_valid    ( enq_valid    )
    );

    queue_store #(
        .queue_depth ( queue_depth )
    ) i_queue_store (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .enq_word     ( enq_word     ),
        .enq_valid    ( enq_valid    ),
        .free_words   ( free_words   ),
        .pkt_avail    ( pkt_avail    ),
        .deq_req      ( deq_req      ),
        .deq_valid    ( deq_valid    ),
        .deq_word     ( deq_word     )
    );

    // Consumer
    egress_scheduler i_egress_scheduler (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .pkt_avail    ( pkt_avail    ),
        .egr_ready    ( egr_ready    ),
        .deq_req      ( deq_req      ),
        .deq_valid    ( deq_valid    ),
        .deq_word     ( deq_word     ),
        .out_word     ( out_word     ),
        .out_valid    ( out_valid    )
    );

endmodule

`default_nettype wire

//--- hw/egress_scheduler.sv
/* Egress packet scheduler */

`timescale 1ns/1ps
`default_nettype none

module egress_scheduler (
    input  logic                                  core_clk_ifc,
    input  logic                                  rst_n,
    input  logic [queue_pkg::num_queues-1:0]      pkt_avail,
    input  logic [router_pkg::num_egr_ports-1:0]  egr_ready,
    output queue_pkg::deq_req_t                   deq_req,
    output logic                                  deq_valid,
    input  router_pkg::stream_word_t              deq_word,
    output router_pkg::stream_word_t              out_word,
    output logic                                  out_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_head,
        st_burst
    } state_t;

    state_t                state;
    queue_pkg::queue_idx_t cur_queue;
    queue_pkg::queue_idx_t pick_queue;
    logic                  pick_found;
    router_pkg::egr_port_t rr_port;
    router_pkg::word_cnt_t words_left;
    router_pkg::word_cnt_t head_left;
    logic                  port_rdy;
    logic                  s1_valid;

    //////////////////////////////////////////////////
    // Queue selection

    // Round robin over ports, high priority first within a port
    always_comb begin
        router_pkg::egr_port_t cand;
        pick_found = 1'b0;
        pick_queue = '0;
        for (int i = 1; i <= router_pkg::num_egr_ports; i++) begin
            cand = rr_port + router_pkg::egr_port_t'(i);
            if (!pick_found && egr_ready[cand] &&
                (pkt_avail[{cand, 1'b1}] || pkt_avail[{cand, 1'b0}])) begin
                pick_found = 1'b1;
                pick_queue = pkt_avail[{cand, 1'b1}] ? {cand, 1'b1} : {cand, 1'b0};
            end
        end
    end

    // Port of the current queue sits in bits 2:1
    assign port_rdy = egr_ready[cur_queue[2:1]];

    // First word is in deq_word during st_head and gives the length
    assign head_left = router_pkg::pkt_words(deq_word.meta.byte_len) - 1'b1;

    //////////////////////////////////////////////////
    // Read issue

    always_comb begin
        deq_valid     = 1'b0;
        deq_req.queue = cur_queue;
        case (state)
            st_idle: begin
                deq_valid     = pick_found;
                deq_req.queue = pick_queue;
            end
            st_head:  deq_valid = port_rdy && (head_left != '0);
            st_burst: deq_valid = port_rdy;
            default:  deq_valid = 1'b0;
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state      <= st_idle;
            rr_port    <= '0;
            words_left <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (pick_found) begin
                        state   <= st_head;
                        rr_port <= pick_queue[2:1];
                    end
                end
                st_head: begin
                    if (head_left == '0) begin
                        state <= st_idle;
                    end else if (port_rdy) begin
                        words_left <= head_left - 1'b1;
                        state      <= (head_left == 1) ? st_idle : st_burst;
                    end else begin
                        words_left <= head_left;
                        state      <= st_burst;
                    end
                end
                st_burst: begin
                    if (port_rdy) begin
                        words_left <= words_left - 1'b1;
                        if (words_left == 1) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (state == st_idle && pick_found) begin
            cur_queue <= pick_queue;
        end
    end

    //////////////////////////////////////////////////
    // Output pipeline

    // Stage 1 is the memory read, stage 2 the output register
    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= deq_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (s1_valid) begin
            out_word <= deq_word;
        end
    end

endmodule

`default_nettype wire

//--- hw/queue_store.sv
/* Per-queue packet storage */

`timescale 1ns/1ps
`default_nettype none

module queue_store #(
    parameter int queue_depth = 16
) (
    input  logic                                 core_clk_ifc,
    input  logic                                 rst_n,
    input  queue_pkg::enq_word_t                 enq_word,
    input  logic                                 enq_valid,
    output logic [$clog2(queue_depth+1)-1:0]     free_words [queue_pkg::num_queues],
    output logic [queue_pkg::num_queues-1:0]     pkt_avail,
    input  queue_pkg::deq_req_t                  deq_req,
    input  logic                                 deq_valid,
    output router_pkg::stream_word_t             deq_word
);

    localparam int ptr_w     = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w     = $clog2(queue_depth + 1);
    localparam int mem_words = queue_pkg::num_queues * queue_depth;
    localparam int addr_w    = $clog2(mem_words);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [cnt_w-1:0] cnt_t;

    // One memory, queue q owns words q*queue_depth and up
    router_pkg::stream_word_t mem [mem_words];

    ptr_t                            wr_ptr  [queue_pkg::num_queues];
    ptr_t                            rd_ptr  [queue_pkg::num_queues];
    cnt_t                            used    [queue_pkg::num_queues];
    cnt_t                            pkt_cnt [queue_pkg::num_queues];
    logic [queue_pkg::num_queues-1:0] wr_hit;
    logic [queue_pkg::num_queues-1:0] rd_hit;
    logic [addr_w-1:0]               wr_addr;
    logic [addr_w-1:0]               rd_addr;
    logic                            wr_last;
    logic                            rd_last;

    function automatic logic [addr_w-1:0] region_addr(queue_pkg::queue_idx_t q, ptr_t p);
        return addr_w'(int'(q) * queue_depth + int'(p));
    endfunction

    // Pointers wrap inside their own region
    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_addr = region_addr(enq_word.queue, wr_ptr[enq_word.queue]);
    assign rd_addr = region_addr(deq_req.queue, rd_ptr[deq_req.queue]);
    assign wr_last = enq_word.word.last;
    // Peek at the word being read so the packet count drops at once
    assign rd_last = mem[rd_addr].last;

    always_comb begin
        for (int q = 0; q < queue_pkg::num_queues; q++) begin
            wr_hit[q]     = enq_valid && (enq_word.queue == queue_pkg::queue_idx_t'(q));
            rd_hit[q]     = deq_valid && (deq_req.queue == queue_pkg::queue_idx_t'(q));
            free_words[q] = cnt_t'(queue_depth) - used[q];
            pkt_avail[q]  = pkt_cnt[q] != '0;
        end
    end

    //////////////////////////////////////////////////
    // Memory

    always_ff @(posedge core_clk_ifc) begin
        if (enq_valid) begin
            mem[wr_addr] <= enq_word.word;
        end
        if (deq_valid) begin
            deq_word <= mem[rd_addr];
        end
    end

    //////////////////////////////////////////////////
    // Pointers and counts

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int q = 0; q < queue_pkg::num_queues; q++) begin
                wr_ptr[q]  <= '0;
                rd_ptr[q]  <= '0;
                used[q]    <= '0;
                pkt_cnt[q] <= '0;
            end
        end else begin
            for (int q = 0; q < queue_pkg::num_queues; q++) begin
                if (wr_hit[q]) begin
                    wr_ptr[q] <= next_ptr(wr_ptr[q]);
                end
                if (rd_hit[q]) begin
                    rd_ptr[q] <= next_ptr(rd_ptr[q]);
                end
                used[q]    <= used[q] + cnt_t'(wr_hit[q]) - cnt_t'(rd_hit[q]);
                // complete packets, counted on last words
                pkt_cnt[q] <= pkt_cnt[q] + cnt_t'(wr_hit[q] && wr_last)
                                         - cnt_t'(rd_hit[q] && rd_last);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pkt_classifier.sv
/* Ingress packet classifier */

`timescale 1ns/1ps
`default_nettype none

module pkt_classifier #(
    parameter int queue_depth = 16
) (
    input  logic                                 core_clk_ifc,
    input  logic                                 rst_n,
    input  router_pkg::stream_word_t             in_word,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  logic [$clog2(queue_depth+1)-1:0]     free_words [queue_pkg::num_queues],
    output queue_pkg::enq_word_t                 enq_word,
    output logic                                 enq_valid
);

    localparam int cnt_w = $clog2(queue_depth + 1);

    // One extra bit so the room check cannot wrap
    typedef logic [cnt_w:0] room_t;

    logic                  mid_pkt;
    queue_pkg::queue_idx_t cur_queue;
    queue_pkg::queue_idx_t pkt_queue;
    room_t                 need_words;
    room_t                 room_words;
    logic                  in_flight;
    logic                  fits;
    logic                  accept;

    //////////////////////////////////////////////////
    // Admission

    // Queue is fixed at the first word and held for the rest
    assign pkt_queue = mid_pkt ? cur_queue : {in_word.meta.egr_port, in_word.meta.prio};

    assign need_words = room_t'(router_pkg::pkt_words(in_word.meta.byte_len));

    // Word in the enqueue register is not yet counted by the store
    assign in_flight  = enq_valid && (enq_word.queue == pkt_queue);
    assign room_words = room_t'(free_words[pkt_queue]) - room_t'(in_flight);
    assign fits       = room_words >= need_words;

    // Space was reserved for the whole packet at its first word
    assign in_ready = mid_pkt || !in_valid || fits;
    assign accept   = in_valid && in_ready;

    //////////////////////////////////////////////////
    // Enqueue register

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            mid_pkt   <= 1'b0;
            enq_valid <= 1'b0;
        end else begin
            enq_valid <= accept;
            if (accept) begin
                mid_pkt <= !in_word.last;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            cur_queue      <= pkt_queue;
            enq_word.queue <= pkt_queue;
            enq_word.word  <= in_word;
        end
    end

endmodule

`default_nettype wire

//--- hw/queue_pkg.sv
/* Queue-level types */

`default_nettype none

package queue_pkg;

    localparam int num_queues = router_pkg::num_egr_ports * router_pkg::queues_per_port;

    // Port number in the upper bits, priority in bit 0
    typedef logic [2:0] queue_idx_t;

    typedef struct packed {
        queue_idx_t               queue;
        router_pkg::stream_word_t word;
    } enq_word_t;

    typedef struct packed {
        queue_idx_t queue;
    } deq_req_t;

endpackage

`default_nettype wire

//--- hw/router_pkg.sv
/* Packet-level types */

`default_nettype none

package router_pkg;

    localparam int num_egr_ports   = 4;
    localparam int queues_per_port = 2;
    localparam int data_bytes      = 8;
    localparam int max_pkt_words   = 8;

    typedef logic [1:0] egr_port_t;
    // 1 is the high priority
    typedef logic       prio_t;
    typedef logic [$clog2(max_pkt_words * data_bytes + 1)-1:0] byte_len_t;
    typedef logic [$clog2(max_pkt_words + 1)-1:0]              word_cnt_t;

    typedef struct packed {
        egr_port_t egr_port;
        prio_t     prio;
        byte_len_t byte_len;
    } pkt_meta_t;

    typedef struct packed {
        logic [data_bytes*8-1:0] data;
        logic                    last;
        pkt_meta_t               meta;
    } stream_word_t;

    // Words needed for a packet, byte length rounded up
    function automatic word_cnt_t pkt_words(byte_len_t len);
        logic [7:0] round_up;
        round_up = 8'(len) + 8'(data_bytes - 1);
        return word_cnt_t'(round_up / 8'(data_bytes));
    endfunction

endpackage

`default_nettype wire
